// ==== rtl/hl_config.svh ====
// shared widths, addresses and timing units; a new settings address needs matching wr_t and settings_t fields
`ifndef HL_CONFIG_SVH
`define HL_CONFIG_SVH

//////////////////////////////////////////////////
// widths
`define HL_CMD_ADDR_W       6
`define HL_CMD_DATA_W       32

//////////////////////////////////////////////////
// identity
// board mac 00:1c:c0:a2:13:dd
`define HL_MAC_DEFAULT      48'h001cc0a213dd
`define HL_VERSION_MAJOR    8'd69
`define HL_VERSION_MINOR    8'd0

//////////////////////////////////////////////////
// timing
// flops per asynchronous pin
`define HL_SYNC_DEPTH       2
// clk_ctrl cycles per hang unit
`define HL_HANG_UNIT        8

//////////////////////////////////////////////////
// command addresses
`define HL_ADDR_GENERAL     6'h00
`define HL_ADDR_STATIC_IP   6'h10
`define HL_ADDR_ALT_MAC     6'h11
`define HL_ADDR_EEPROM_CFG  6'h12
`define HL_ADDR_TX_HANG     6'h17

`endif

// ==== rtl/hl_pkg.sv ====
// types shared by the control path; field order sets the bit layout of cmd_t and resp_t on the pins
`include "hl_config.svh"

package hl_pkg;

  //////////////////////////////////////////////////
  // host side

  // command word, addr in the top bits
  typedef struct packed {
    logic [`HL_CMD_ADDR_W-1:0] addr;
    logic [`HL_CMD_DATA_W-1:0] data;
    logic                      ptt;
    logic                      requires_resp;
  } cmd_t;

  // reply word
  typedef struct packed {
    logic [`HL_CMD_ADDR_W-1:0] addr;
    logic                      rxclip;
    logic                      rxgoodlvl;
    logic [`HL_CMD_DATA_W-1:0] data;
  } resp_t;

  //////////////////////////////////////////////////
  // internal

  // one strobe per settings address
  typedef struct packed {
    logic                      wr_general;
    logic                      wr_static_ip;
    logic                      wr_alt_mac;
    logic                      wr_eeprom_cfg;
    logic                      wr_tx_hang;
    logic [`HL_CMD_DATA_W-1:0] data;
  } wr_t;

  typedef struct packed {
    logic        run;
    logic        wide_spectrum;
    logic [31:0] static_ip;
    logic [15:0] alt_mac;
    logic [7:0]  eeprom_cfg;
    logic [9:0]  tx_hang;
  } settings_t;

  // receive level flags from the converter side
  typedef struct packed {
    logic rxclip;
    logic rxgoodlvl;
  } rx_status_t;

  typedef struct packed {
    logic tx_inhibit;
    logic alternate_mac;
  } io_pins_t;

endpackage

// ==== rtl/sync_stage.sv ====
// for level signals only; a pulse shorter than one clk_ctrl period may be lost, output lags DEPTH cycles
module sync_stage #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk_ctrl,
  input  logic     rst_n_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

  // a single flop leaves metastability on q_o
  a_min_depth: assert property (@(posedge clk_ctrl) DEPTH >= 2)
    else $error("sync_stage depth below 2");

endmodule

// ==== rtl/cmd_control.sv ====
// cmd_valid_i must be a one-cycle pulse per command; writes to unknown addresses are dropped silently
`include "hl_config.svh"

module cmd_control (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      cmd_valid_i,
  input  hl_pkg::cmd_t              cmd_i,
  output hl_pkg::wr_t               wr_o,
  output logic                      ptt_wr_o,
  output logic                      ptt_o,
  output logic                      resp_req_o,
  output logic [`HL_CMD_ADDR_W-1:0] resp_addr_o
);

  hl_pkg::wr_t               wr_next;
  hl_pkg::wr_t               wr_q;
  logic                      ptt_wr_q;
  logic                      ptt_q;
  logic                      req_s1_q;
  logic [`HL_CMD_ADDR_W-1:0] addr_s1_q;
  logic                      req_s2_q;
  logic [`HL_CMD_ADDR_W-1:0] addr_s2_q;

  //////////////////////////////////////////////////
  // address decode
  always_comb begin
    wr_next      = '0;
    wr_next.data = cmd_i.data;
    if (cmd_valid_i) begin
      case (cmd_i.addr)
        `HL_ADDR_GENERAL:    wr_next.wr_general    = 1'b1;
        `HL_ADDR_STATIC_IP:  wr_next.wr_static_ip  = 1'b1;
        `HL_ADDR_ALT_MAC:    wr_next.wr_alt_mac    = 1'b1;
        `HL_ADDR_EEPROM_CFG: wr_next.wr_eeprom_cfg = 1'b1;
        `HL_ADDR_TX_HANG:    wr_next.wr_tx_hang    = 1'b1;
        default:             wr_next.wr_general    = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // stage 1 and stage 2
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_q      <= '0;
      ptt_wr_q  <= 1'b0;
      ptt_q     <= 1'b0;
      req_s1_q  <= 1'b0;
      addr_s1_q <= '0;
      req_s2_q  <= 1'b0;
      addr_s2_q <= '0;
    end else begin
      wr_q      <= wr_next;
      // every command carries the current ptt state
      ptt_wr_q  <= cmd_valid_i;
      if (cmd_valid_i) begin
        ptt_q <= cmd_i.ptt;
      end
      req_s1_q  <= cmd_valid_i & cmd_i.requires_resp;
      addr_s1_q <= cmd_i.addr;
      // reply waits for the write to land in setting_regs
      req_s2_q  <= req_s1_q;
      addr_s2_q <= addr_s1_q;
    end
  end

  assign wr_o        = wr_q;
  assign ptt_wr_o    = ptt_wr_q;
  assign ptt_o       = ptt_q;
  assign resp_req_o  = req_s2_q;
  assign resp_addr_o = addr_s2_q;

  a_one_strobe: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $onehot0({wr_q.wr_general, wr_q.wr_static_ip, wr_q.wr_alt_mac,
              wr_q.wr_eeprom_cfg, wr_q.wr_tx_hang}))
    else $error("more than one settings strobe active");

endmodule

// ==== rtl/setting_regs.sv ====
// local_mac_o is combinational from the registers and the synchronized pin; alt_mac_pin_i must be synchronized
`include "hl_config.svh"

module setting_regs (
  input  logic              clk_ctrl,
  input  logic              rst_n_i,
  input  hl_pkg::wr_t       wr_i,
  input  logic              alt_mac_pin_i,
  output hl_pkg::settings_t settings_o,
  output logic [47:0]       local_mac_o
);

  localparam logic [47:0] MAC_DEFAULT = `HL_MAC_DEFAULT;

  hl_pkg::settings_t settings_q;

  //////////////////////////////////////////////////
  // register file
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      settings_q <= '0;
    end else begin
      if (wr_i.wr_general) begin
        settings_q.run           <= wr_i.data[0];
        settings_q.wide_spectrum <= wr_i.data[1];
      end
      if (wr_i.wr_static_ip) begin
        settings_q.static_ip <= wr_i.data;
      end
      if (wr_i.wr_alt_mac) begin
        settings_q.alt_mac <= wr_i.data[15:0];
      end
      if (wr_i.wr_eeprom_cfg) begin
        settings_q.eeprom_cfg <= wr_i.data[7:0];
      end
      if (wr_i.wr_tx_hang) begin
        settings_q.tx_hang <= wr_i.data[9:0];
      end
    end
  end

  assign settings_o = settings_q;

  //////////////////////////////////////////////////
  // local mac
  // cfg bit 6 swaps in the programmed tail, else the pin picks one of two boards
  always_comb begin
    if (settings_q.eeprom_cfg[6]) begin
      local_mac_o = {MAC_DEFAULT[47:16], settings_q.alt_mac};
    end else begin
      local_mac_o = {MAC_DEFAULT[47:2], ~alt_mac_pin_i, MAC_DEFAULT[0]};
    end
  end

endmodule

// ==== rtl/tx_keyer.sv ====
// inhibit_i must be synchronized; hang length is taken from hang_i at the moment tx_on_o falls
`include "hl_config.svh"

module tx_keyer (
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  logic       ptt_wr_i,
  input  logic       ptt_i,
  input  logic       run_i,
  input  logic       inhibit_i,
  input  logic [9:0] hang_i,
  output logic       tx_on_o,
  output logic       tx_hang_o
);

  localparam int CNT_W = 10 + $clog2(`HL_HANG_UNIT);

  logic             ptt_q;
  logic             ptt_next;
  logic             tx_on_next;
  logic             tx_on_q;
  logic             hang_q;
  logic [CNT_W-1:0] hang_cnt_q;
  logic [CNT_W-1:0] hang_load;

  // ptt update takes effect on the edge that latches it
  assign ptt_next   = ptt_wr_i ? ptt_i : ptt_q;
  assign tx_on_next = ptt_next & run_i & ~inhibit_i;
  assign hang_load  = CNT_W'(hang_i) * CNT_W'(`HL_HANG_UNIT);

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptt_q      <= 1'b0;
      tx_on_q    <= 1'b0;
      hang_q     <= 1'b0;
      hang_cnt_q <= '0;
    end else begin
      ptt_q   <= ptt_next;
      tx_on_q <= tx_on_next;
      if (tx_on_next) begin
        // rekeyed, hang ends at once
        hang_q     <= 1'b0;
        hang_cnt_q <= '0;
      end else if (tx_on_q) begin
        // falling edge of tx_on
        hang_q     <= (hang_i != 10'd0);
        hang_cnt_q <= hang_load - CNT_W'(1);
      end else if (hang_q) begin
        if (hang_cnt_q == '0) begin
          hang_q <= 1'b0;
        end else begin
          hang_cnt_q <= hang_cnt_q - CNT_W'(1);
        end
      end
    end
  end

  assign tx_on_o   = tx_on_q;
  assign tx_hang_o = hang_q;

  a_on_hang_excl: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !(tx_on_o && tx_hang_o))
    else $error("tx_on and tx_hang high together");

endmodule

// ==== rtl/resp_builder.sv ====
// one reply per request with no queue; status_i must be synchronized, flags clear on every reply sent
`include "hl_config.svh"

module resp_builder (
  input  logic                      clk_ctrl,
  input  logic                      rst_n_i,
  input  logic                      resp_req_i,
  input  logic [`HL_CMD_ADDR_W-1:0] resp_addr_i,
  input  hl_pkg::settings_t         settings_i,
  input  hl_pkg::rx_status_t        status_i,
  output logic                      resp_valid_o,
  output hl_pkg::resp_t             resp_o
);

  logic                      resp_valid_q;
  hl_pkg::resp_t             resp_q;
  logic                      clip_q;
  logic                      goodlvl_q;
  logic                      clip_now;
  logic                      goodlvl_now;
  logic [`HL_CMD_DATA_W-1:0] rd_data;

  // include this cycle so a hit is never lost on a clear
  assign clip_now    = clip_q | status_i.rxclip;
  assign goodlvl_now = goodlvl_q | status_i.rxgoodlvl;

  //////////////////////////////////////////////////
  // readback select
  always_comb begin
    case (resp_addr_i)
      `HL_ADDR_GENERAL:    rd_data = {30'd0, settings_i.wide_spectrum, settings_i.run};
      `HL_ADDR_STATIC_IP:  rd_data = settings_i.static_ip;
      `HL_ADDR_ALT_MAC:    rd_data = {16'd0, settings_i.alt_mac};
      `HL_ADDR_EEPROM_CFG: rd_data = {24'd0, settings_i.eeprom_cfg};
      `HL_ADDR_TX_HANG:    rd_data = {22'd0, settings_i.tx_hang};
      // version word for everything else
      default:             rd_data = {`HL_VERSION_MAJOR, `HL_VERSION_MINOR, 16'd0};
    endcase
  end

  //////////////////////////////////////////////////
  // sticky flags and reply valid
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
      clip_q       <= 1'b0;
      goodlvl_q    <= 1'b0;
    end else begin
      resp_valid_q <= resp_req_i;
      if (resp_req_i) begin
        clip_q    <= status_i.rxclip;
        goodlvl_q <= status_i.rxgoodlvl;
      end else begin
        clip_q    <= clip_now;
        goodlvl_q <= goodlvl_now;
      end
    end
  end

  // reply payload
  always_ff @(posedge clk_ctrl) begin
    if (resp_req_i) begin
      resp_q.addr      <= resp_addr_i;
      resp_q.rxclip    <= clip_now;
      resp_q.rxgoodlvl <= goodlvl_now;
      resp_q.data      <= rd_data;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// ==== rtl/hl_ctrl_top.sv ====
// single clk_ctrl domain, no back-pressure; a command may arrive every cycle and up to three are in flight
`include "hl_config.svh"

module hl_ctrl_top (
  input  logic           clk_ctrl,
  input  logic           rst_n_i,
  input  logic           cmd_valid_i,
  input  hl_pkg::cmd_t   cmd_i,
  input  logic           rxclip_i,
  input  logic           rxgoodlvl_i,
  input  logic           io_tx_inhibit_i,
  input  logic           io_alternate_mac_i,
  output logic           resp_valid_o,
  output hl_pkg::resp_t  resp_o,
  output logic           run_o,
  output logic [31:0]    static_ip_o,
  output logic [47:0]    local_mac_o,
  output logic           tx_on_o,
  output logic           tx_hang_o
);

  hl_pkg::rx_status_t        rx_status_raw;
  hl_pkg::rx_status_t        rx_status_sync;
  hl_pkg::io_pins_t          io_pins_raw;
  hl_pkg::io_pins_t          io_pins_sync;
  hl_pkg::wr_t               wr;
  hl_pkg::settings_t         settings;
  logic                      ptt_wr;
  logic                      ptt;
  logic                      resp_req;
  logic [`HL_CMD_ADDR_W-1:0] resp_addr;

  //////////////////////////////////////////////////
  // asynchronous pins
  assign rx_status_raw.rxclip        = rxclip_i;
  assign rx_status_raw.rxgoodlvl     = rxgoodlvl_i;
  assign io_pins_raw.tx_inhibit      = io_tx_inhibit_i;
  assign io_pins_raw.alternate_mac   = io_alternate_mac_i;

  sync_stage #(
    .payload_t (hl_pkg::rx_status_t),
    .DEPTH     (`HL_SYNC_DEPTH)
  ) u_sync_rx_status (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .d_i      (rx_status_raw),
    .q_o      (rx_status_sync)
  );

  sync_stage #(
    .payload_t (hl_pkg::io_pins_t),
    .DEPTH     (`HL_SYNC_DEPTH)
  ) u_sync_io_pins (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .d_i      (io_pins_raw),
    .q_o      (io_pins_sync)
  );

  //////////////////////////////////////////////////
  // control and datapath
  cmd_control u_cmd_control (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .wr_o        (wr),
    .ptt_wr_o    (ptt_wr),
    .ptt_o       (ptt),
    .resp_req_o  (resp_req),
    .resp_addr_o (resp_addr)
  );

  setting_regs u_setting_regs (
    .clk_ctrl      (clk_ctrl),
    .rst_n_i       (rst_n_i),
    .wr_i          (wr),
    .alt_mac_pin_i (io_pins_sync.alternate_mac),
    .settings_o    (settings),
    .local_mac_o   (local_mac_o)
  );

  tx_keyer u_tx_keyer (
    .clk_ctrl  (clk_ctrl),
    .rst_n_i   (rst_n_i),
    .ptt_wr_i  (ptt_wr),
    .ptt_i     (ptt),
    .run_i     (settings.run),
    .inhibit_i (io_pins_sync.tx_inhibit),
    .hang_i    (settings.tx_hang),
    .tx_on_o   (tx_on_o),
    .tx_hang_o (tx_hang_o)
  );

  resp_builder u_resp_builder (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .resp_req_i   (resp_req),
    .resp_addr_i  (resp_addr),
    .settings_i   (settings),
    .status_i     (rx_status_sync),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  assign run_o       = settings.run;
  assign static_ip_o = settings.static_ip;

endmodule

// ==== sim/tb_hl_ctrl_top.sv ====
// checks are concurrent assertions; status and io pins stay low except where a test drives them
`include "hl_config.svh"

module tb_hl_ctrl_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [47:0]               MAC_DEF     = `HL_MAC_DEFAULT;
  localparam logic [`HL_CMD_ADDR_W-1:0] ADDR_UNUSED = 6'h3f;

  logic              clk_ctrl;
  logic              rst_n_i;
  logic              cmd_valid_i;
  hl_pkg::cmd_t      cmd_i;
  logic              rxclip_i;
  logic              rxgoodlvl_i;
  logic              io_tx_inhibit_i;
  logic              io_alternate_mac_i;
  logic              resp_valid_o;
  hl_pkg::resp_t     resp_o;
  logic              run_o;
  logic [31:0]       static_ip_o;
  logic [47:0]       local_mac_o;
  logic              tx_on_o;
  logic              tx_hang_o;

  // reference model of the settings and sticky flags
  hl_pkg::settings_t m_set;
  logic              cur_ptt;
  logic              sticky_clip;
  logic              sticky_good;
  logic [31:0]       exp_data;
  logic              exp_clip;
  logic              exp_good;
  logic              chk_mac_alt;
  int                hang_len;
  int                errors;
  int                errors_at_start;
  int                tests;
  integer            seed;

  hl_ctrl_top u_hl_ctrl_top (
    .clk_ctrl           (clk_ctrl),
    .rst_n_i            (rst_n_i),
    .cmd_valid_i        (cmd_valid_i),
    .cmd_i              (cmd_i),
    .rxclip_i           (rxclip_i),
    .rxgoodlvl_i        (rxgoodlvl_i),
    .io_tx_inhibit_i    (io_tx_inhibit_i),
    .io_alternate_mac_i (io_alternate_mac_i),
    .resp_valid_o       (resp_valid_o),
    .resp_o             (resp_o),
    .run_o              (run_o),
    .static_ip_o        (static_ip_o),
    .local_mac_o        (local_mac_o),
    .tx_on_o            (tx_on_o),
    .tx_hang_o          (tx_hang_o)
  );

  initial clk_ctrl = 1'b0;
  always #50 clk_ctrl = ~clk_ctrl;

  // consecutive cycles of tx_hang_o
  always @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hang_len <= 0;
    end else if (tx_hang_o) begin
      hang_len <= hang_len + 1;
    end else begin
      hang_len <= 0;
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // assertions
  a_reset: assert property (@(posedge clk_ctrl) !rst_n_i || $rose(rst_n_i) |->
    !tx_on_o && !tx_hang_o && !resp_valid_o && !run_o && static_ip_o == 32'd0
    && local_mac_o == {MAC_DEF[47:2], 1'b1, MAC_DEF[0]})
    else report_error("outputs not in reset state");

  a_ip_latency: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    cmd_valid_i && cmd_i.addr == `HL_ADDR_STATIC_IP |->
    ##1 (static_ip_o == $past(static_ip_o))
    ##1 (static_ip_o == $past(cmd_i.data, 2)))
    else report_error("static_ip_o not updated exactly two edges after write");

  a_reply: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    cmd_valid_i && cmd_i.requires_resp |->
    ##3 resp_valid_o && resp_o.addr == $past(cmd_i.addr, 3)
    && resp_o.data == $past(exp_data, 3) && resp_o.rxclip == $past(exp_clip, 3)
    && resp_o.rxgoodlvl == $past(exp_good, 3))
    else report_error("reply missing or address, data or flags wrong");

  a_no_extra_reply: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_valid_o |-> $past(cmd_valid_i && cmd_i.requires_resp, 3))
    else report_error("reply without a request");

  a_mac_pin_rise: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $rose(io_alternate_mac_i) && !m_set.eeprom_cfg[6] |->
    ##2 local_mac_o == {MAC_DEF[47:2], 1'b0, MAC_DEF[0]})
    else report_error("local mac bit 1 not cleared by pin");

  a_mac_pin_fall: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $fell(io_alternate_mac_i) && !m_set.eeprom_cfg[6] |->
    ##2 local_mac_o == {MAC_DEF[47:2], 1'b1, MAC_DEF[0]})
    else report_error("local mac bit 1 not set by pin");

  a_mac_alt: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    chk_mac_alt |-> local_mac_o == {MAC_DEF[47:16], m_set.alt_mac})
    else report_error("local mac does not carry the alternate tail");

  a_key_on: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    cmd_valid_i && cmd_i.ptt && run_o && !io_tx_inhibit_i
    && $past(!io_tx_inhibit_i) && $past(!io_tx_inhibit_i, 2) |-> ##2 tx_on_o)
    else report_error("tx_on_o not raised by ptt");

  a_inhibit: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $rose(io_tx_inhibit_i) |-> ##[1:3] !tx_on_o)
    else report_error("tx_on_o not dropped by inhibit");

  a_run_gate: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !$past(run_o) |-> !tx_on_o)
    else report_error("tx_on_o high while run is 0");

  a_hang_start: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $fell(tx_on_o) |-> tx_hang_o == (m_set.tx_hang != 10'd0))
    else report_error("tx_hang_o wrong as tx_on_o falls");

  a_hang_len: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $fell(tx_hang_o) && !tx_on_o |-> hang_len == int'(m_set.tx_hang) * `HL_HANG_UNIT)
    else report_error("tx_hang_o length wrong");

  //////////////////////////////////////////////////
  // model and stimulus tasks
  task automatic update_model(input logic [`HL_CMD_ADDR_W-1:0] addr, input logic [31:0] data);
    case (addr)
      `HL_ADDR_GENERAL: begin
        m_set.run           = data[0];
        m_set.wide_spectrum = data[1];
      end
      `HL_ADDR_STATIC_IP:  m_set.static_ip  = data;
      `HL_ADDR_ALT_MAC:    m_set.alt_mac    = data[15:0];
      `HL_ADDR_EEPROM_CFG: m_set.eeprom_cfg = data[7:0];
      `HL_ADDR_TX_HANG:    m_set.tx_hang    = data[9:0];
      default:             m_set.tx_hang    = m_set.tx_hang;
    endcase
  endtask

  function automatic logic [31:0] read_model(input logic [`HL_CMD_ADDR_W-1:0] addr);
    case (addr)
      `HL_ADDR_GENERAL:    read_model = {30'd0, m_set.wide_spectrum, m_set.run};
      `HL_ADDR_STATIC_IP:  read_model = m_set.static_ip;
      `HL_ADDR_ALT_MAC:    read_model = {16'd0, m_set.alt_mac};
      `HL_ADDR_EEPROM_CFG: read_model = {24'd0, m_set.eeprom_cfg};
      `HL_ADDR_TX_HANG:    read_model = {22'd0, m_set.tx_hang};
      default:             read_model = {`HL_VERSION_MAJOR, `HL_VERSION_MINOR, 16'd0};
    endcase
  endfunction

  // called on a rising edge, returns one edge later
  task automatic send_cmd(input logic [`HL_CMD_ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic req);
    hl_pkg::cmd_t c;
    c.addr          = addr;
    c.data          = data;
    c.ptt           = cur_ptt;
    c.requires_resp = req;
    update_model(addr, data);
    cmd_i       <= c;
    cmd_valid_i <= 1'b1;
    exp_data    <= read_model(addr);
    exp_clip    <= sticky_clip;
    exp_good    <= sticky_good;
    if (req) begin
      sticky_clip = 1'b0;
      sticky_good = 1'b0;
    end
    @(posedge clk_ctrl);
    cmd_valid_i <= 1'b0;
  endtask

  // rewrites the current value, so nothing changes
  task automatic read_reg(input logic [`HL_CMD_ADDR_W-1:0] addr);
    send_cmd(addr, read_model(addr), 1'b1);
  endtask

  task automatic wait_reply();
    int  n;
    logic got;
    n   = 0;
    got = 1'b0;
    while (!got && n < 20) begin
      @(posedge clk_ctrl);
      got = resp_valid_o;
      n++;
    end
    if (!got) begin
      errors++;
      $display("no reply arrived within 20 cycles at t=%0t", $time);
    end
  endtask

  task automatic wait_hang_done();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (n < 200 && !(seen && !tx_hang_o)) begin
      @(posedge clk_ctrl);
      if (tx_hang_o) begin
        seen = 1'b1;
      end
      n++;
    end
    if (!(seen && !tx_hang_o)) begin
      errors++;
      $display("hang time did not start or did not end within 200 cycles");
    end
    repeat (2) @(posedge clk_ctrl);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  //////////////////////////////////////////////////
  // tests
  initial begin
    logic [31:0] rnd;
    int          hang_units;
    seed               = 32'h356bcef2;
    errors             = 0;
    errors_at_start    = 0;
    tests              = 0;
    m_set              = '0;
    cur_ptt            = 1'b0;
    sticky_clip        = 1'b0;
    sticky_good        = 1'b0;
    chk_mac_alt        = 1'b0;
    exp_data           = '0;
    exp_clip           = 1'b0;
    exp_good           = 1'b0;
    cmd_valid_i        = 1'b0;
    cmd_i              = '0;
    rxclip_i           = 1'b0;
    rxgoodlvl_i        = 1'b0;
    io_tx_inhibit_i    = 1'b0;
    io_alternate_mac_i = 1'b0;
    rst_n_i            = 1'b1;
    #1;
    rst_n_i = 1'b0;
    repeat (10) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge clk_ctrl);
    end_test("reset state");

    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      send_cmd(`HL_ADDR_STATIC_IP, rnd, 1'b0);
      repeat (2) @(posedge clk_ctrl);
      read_reg(`HL_ADDR_STATIC_IP);
      wait_reply();
      // back to back write and read
      rnd = $random(seed);
      send_cmd(`HL_ADDR_ALT_MAC, rnd, 1'b0);
      read_reg(`HL_ADDR_ALT_MAC);
      wait_reply();
      rnd = $random(seed);
      send_cmd(`HL_ADDR_EEPROM_CFG, rnd, 1'b1);
      wait_reply();
    end
    // three in flight
    send_cmd(`HL_ADDR_STATIC_IP, $random(seed), 1'b1);
    send_cmd(`HL_ADDR_GENERAL, 32'd0, 1'b1);
    send_cmd(6'h2a, 32'd0, 1'b1);
    repeat (3) wait_reply();
    end_test("write and readback");

    send_cmd(`HL_ADDR_EEPROM_CFG, 32'h0000_0005, 1'b0);
    repeat (4) @(posedge clk_ctrl);
    for (int i = 0; i < 2; i++) begin
      io_alternate_mac_i <= 1'b1;
      repeat (4) @(posedge clk_ctrl);
      io_alternate_mac_i <= 1'b0;
      repeat (4) @(posedge clk_ctrl);
    end
    send_cmd(`HL_ADDR_ALT_MAC, $random(seed), 1'b0);
    send_cmd(`HL_ADDR_EEPROM_CFG, 32'h0000_0040, 1'b1);
    wait_reply();
    chk_mac_alt = 1'b1;
    // pin has no effect with the tail selected
    io_alternate_mac_i <= 1'b1;
    repeat (4) @(posedge clk_ctrl);
    io_alternate_mac_i <= 1'b0;
    repeat (4) @(posedge clk_ctrl);
    chk_mac_alt = 1'b0;
    end_test("local mac");

    // ptt with run off
    cur_ptt = 1'b1;
    send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
    repeat (6) @(posedge clk_ctrl);
    cur_ptt = 1'b0;
    send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
    send_cmd(`HL_ADDR_GENERAL, 32'd1, 1'b0);
    repeat (4) @(posedge clk_ctrl);
    cur_ptt = 1'b1;
    send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
    repeat (4) @(posedge clk_ctrl);
    io_tx_inhibit_i <= 1'b1;
    repeat (6) @(posedge clk_ctrl);
    io_tx_inhibit_i <= 1'b0;
    repeat (6) @(posedge clk_ctrl);
    cur_ptt = 1'b0;
    send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
    repeat (4) @(posedge clk_ctrl);
    end_test("keying and inhibit");

    for (int i = 0; i < 3; i++) begin
      hang_units = ($unsigned($random(seed)) % 20) + 1;
      send_cmd(`HL_ADDR_TX_HANG, hang_units, 1'b0);
      repeat (3) @(posedge clk_ctrl);
      cur_ptt = 1'b1;
      send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
      repeat (4) @(posedge clk_ctrl);
      cur_ptt = 1'b0;
      send_cmd(ADDR_UNUSED, 32'd0, 1'b0);
      wait_hang_done();
    end
    end_test("hang time");

    rxclip_i <= 1'b1;
    @(posedge clk_ctrl);
    rxclip_i <= 1'b0;
    repeat (4) @(posedge clk_ctrl);
    sticky_clip = 1'b1;
    read_reg(6'h2a);
    wait_reply();
    read_reg(6'h2a);
    wait_reply();
    rxgoodlvl_i <= 1'b1;
    @(posedge clk_ctrl);
    rxgoodlvl_i <= 1'b0;
    repeat (4) @(posedge clk_ctrl);
    sticky_good = 1'b1;
    read_reg(`HL_ADDR_STATIC_IP);
    wait_reply();
    read_reg(`HL_ADDR_STATIC_IP);
    wait_reply();
    repeat (4) @(posedge clk_ctrl);
    end_test("sticky status");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/hl_pkg.sv
rtl/sync_stage.sv
rtl/cmd_control.sv
rtl/setting_regs.sv
rtl/tx_keyer.sv
rtl/resp_builder.sv
rtl/hl_ctrl_top.sv
sim/tb_hl_ctrl_top.sv
